// ==== bench/board_ctrl_checker.sv ====
`include "board_ctrl_defines.svh"

module board_ctrl_checker import board_ctrl_pkg::*; (
  input  logic                   clk_master,
  input  logic                   reset_mon,
  input  logic                   host_cs_n_i,
  input  logic                   host_we_n_i,
  input  logic [`BC_ADDR_W-1:0]  host_addr_i,
  input  logic [`BC_DATA_W-1:0]  host_wdata_i,
  input  logic [`BC_DATA_W-1:0]  host_rdata_i,
  input  logic                   host_rdy_i,
  input  logic [7:0]             sys_config_i,
  input  logic [3:0]             user_dip_i,
  input  logic [3:0]             config_dip_i,
  input  logic [1:0]             user_led_n_i,
  input  logic                   geth_reset_n_i,
  input  logic                   por_force_i,
  input  logic                   eeprom_wp_i,
  input  logic                   flash_wp_n_i,
  input  logic                   boot_done_i,
  input  logic                   cfg_done_i,
  input  logic                   cfg_cclk_i,
  input  logic                   cfg_din_i,
  input  logic                   cfg_prog_n_i,
  input  logic [`BOOT_LEN*8-1:0] rom_image_i,
  output int                     err_count_o,
  output int                     check_count_o,
  output int                     pending_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [15:0] REV_ID_VAL  = `REV_ID;
  localparam logic [15:0] REV_RCS_VAL = `REV_RCS;
  localparam int          PROG_CYCLES = 8;

  logic [3:0] ctrl_m;          // ctrl register model
  logic       por_m;
  logic       started;
  logic       in_reset = 1'b0;
  logic       req_we;
  logic [4:0] req_addr;
  logic [7:0] exp_rdata;
  logic [7:0] exp_mask;
  logic       last_cclk;
  logic [7:0] shift;
  logic [7:0] stream_q [$];    // bytes still owed on cfg_din_o
  int         bit_cnt;
  int         low_cnt;
  int         prog_exp;
  int         prog_seen;
  int         errors = 0;
  int         checks = 0;
  int         i;

  function automatic logic [7:0] expected_read(input logic [4:0] addr);
    case (addr)
      OFF_CTRL:       return {4'h0, ctrl_m};
      OFF_SWITCHES:   return {config_dip_i, user_dip_i};
      OFF_SYS_CONFIG: return sys_config_i;
      OFF_REV_ID_HI:  return REV_ID_VAL[15:8];
      OFF_REV_ID_LO:  return REV_ID_VAL[7:0];
      OFF_REV_MAJOR:  return `REV_MAJOR;
      OFF_REV_MINOR:  return `REV_MINOR;
      OFF_REV_RCS_HI: return REV_RCS_VAL[15:8];
      OFF_REV_RCS_LO: return REV_RCS_VAL[7:0];
      OFF_CFG_STATUS: return {7'h00, cfg_done_i};
      default:        return 8'h00;
    endcase
  endfunction

  // status only models the done bit
  function automatic logic [7:0] read_mask(input logic [4:0] addr);
    case (addr)
      OFF_CFG_STATUS: return 8'h01;
      default:        return 8'hff;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic model_write(input logic [4:0] addr, input logic [7:0] wdata);
    if (addr == OFF_CTRL) begin
      if (wdata[3] && !ctrl_m[3]) por_m = 1'b1;  // sticky
      ctrl_m = wdata[3:0];
    end
    if (addr == OFF_CFG_DATA) stream_q.push_back(wdata);
    if (addr == OFF_CFG_CTRL && wdata[0]) prog_exp++;
  endtask

  task automatic check_outputs();
    compare_value("user_led_n_o", {6'h00, user_led_n_i}, {6'h00, ~ctrl_m[1:0]});
    compare_value("geth_reset_n_o", 8'(geth_reset_n_i), 8'(!ctrl_m[2]));
    compare_value("por_force_o", 8'(por_force_i), 8'(por_m));
    compare_value("eeprom_wp_o", 8'(eeprom_wp_i), 8'(!user_dip_i[3]));
    compare_value("flash_wp_n_o", 8'(flash_wp_n_i), 8'(!user_dip_i[2]));
  endtask

  always @(posedge clk_master) begin
    if (reset_mon) begin
      if (in_reset) begin
        compare_value("host_rdy_o", 8'(host_rdy_i), 8'h00);
        compare_value("cfg_cclk_o", 8'(cfg_cclk_i), 8'h00);
        compare_value("cfg_prog_n_o", 8'(cfg_prog_n_i), 8'h01);
        compare_value("boot_done_o", 8'(boot_done_i), 8'h00);
        check_outputs();
      end
      in_reset  = 1'b1;
      started   = 1'b0;
      ctrl_m    = 4'h0;
      por_m     = 1'b0;
      last_cclk = 1'b0;
      bit_cnt   = 0;
      low_cnt   = 0;
      prog_exp  = 0;
      prog_seen = 0;
      stream_q.delete();
    end else begin
      in_reset = 1'b0;
      if (!started) begin  // strap seen on the same edge as the loader
        started = 1'b1;
        if (sys_config_i[1]) begin
          for (i = 0; i < `BOOT_LEN; i++) stream_q.push_back(rom_image_i[i*8 +: 8]);
        end
      end
      if (!host_cs_n_i) begin
        req_we    = !host_we_n_i;
        req_addr  = host_addr_i;
        exp_rdata = expected_read(host_addr_i);
        exp_mask  = read_mask(host_addr_i);
        if (req_we) model_write(host_addr_i, host_wdata_i);
      end
      if (host_rdy_i) begin
        if (!req_we) begin
          compare_value($sformatf("host_rdata_o at 0x%02h", req_addr),
                        host_rdata_i & exp_mask, exp_rdata & exp_mask);
        end
        check_outputs();
      end
      if (cfg_cclk_i && !last_cclk) begin  // msb first
        shift = {shift[6:0], cfg_din_i};
        bit_cnt++;
        if (bit_cnt == 8) begin
          bit_cnt = 0;
          if (stream_q.size() == 0) begin
            errors++;
            $display("serial byte 0x%02h arrived when no byte was expected", shift);
          end else begin
            compare_value("cfg_din_o byte", shift, stream_q.pop_front());
          end
        end
      end
      last_cclk = cfg_cclk_i;
      if (!cfg_prog_n_i) begin
        low_cnt++;
      end else if (low_cnt != 0) begin
        prog_seen++;
        compare_value("cfg_prog_n_o low cycles", 8'(low_cnt), 8'(PROG_CYCLES));
        if (prog_seen > prog_exp) begin
          errors++;
          $display("program pulse on cfg_prog_n_o without a cfg_ctrl write");
        end
        low_cnt = 0;
      end
    end
    err_count_o   <= errors;
    check_count_o <= checks;
    pending_o     <= stream_q.size() + prog_exp - prog_seen + low_cnt + bit_cnt;
  end

endmodule

// ==== bench/board_ctrl_sva.sv ====
`include "board_ctrl_defines.svh"

module board_ctrl_sva (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic       cyc_i,
  input  logic       ack_i,
  input  logic [3:0] level_i,
  input  logic       slave_ack_i,
  input  logic       host_ack_i,
  input  logic       boot_ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // assertion failures so far

  assert property (@(posedge clk_master) disable iff (reset_mon)
    level_i <= `CFG_FIFO_DEPTH)
    else begin
      fail_count++;
      $error("configuration fifo level above its depth");
    end

  assert property (@(posedge clk_master) disable iff (reset_mon) ack_i |-> cyc_i)
    else begin
      fail_count++;
      $error("ack seen without cyc");
    end

  // every slave ack reaches exactly one master
  assert property (@(posedge clk_master) disable iff (reset_mon)
    slave_ack_i |-> (host_ack_i ^ boot_ack_i))
    else begin
      fail_count++;
      $error("slave ack not passed to exactly one master");
    end

endmodule

bind config_port board_ctrl_sva u_cfg_sva (
  .clk_master  (clk_master),
  .reset_mon   (reset_mon),
  .cyc_i       (bus.cyc),
  .ack_i       (bus.ack),
  .level_i     (4'(fifo_cnt_q)),
  .slave_ack_i (1'b0),
  .host_ack_i  (1'b0),
  .boot_ack_i  (1'b0)
);

bind bus_arbiter board_ctrl_sva u_arb_sva (
  .clk_master  (clk_master),
  .reset_mon   (reset_mon),
  .cyc_i       (host_bus.cyc),
  .ack_i       (host_bus.ack),
  .level_i     (4'h0),
  .slave_ack_i (misc_bus.ack || cfg_bus.ack),
  .host_ack_i  (host_bus.ack),
  .boot_ack_i  (boot_bus.ack)
);

// ==== bench/board_ctrl_tb.sv ====
`include "board_ctrl_defines.svh"

module board_ctrl_tb import board_ctrl_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CFG_BYTES     = 6;    // host bytes serialized after boot
  localparam int ACCESS_BUDGET = 200;  // upper bound on host accesses
  localparam int CYCLE_LIMIT   =
    ((`BOOT_LEN + CFG_BYTES) * 16 + 40 * ACCESS_BUDGET) * 5 / 4;

  logic                    clk_master;
  logic                    reset_mon;
  logic                    host_cs_n_i;
  logic                    host_we_n_i;
  logic [`BC_ADDR_W-1:0]   host_addr_i;
  logic [`BC_DATA_W-1:0]   host_wdata_i;
  logic [`BC_DATA_W-1:0]   host_rdata_o;
  logic                    host_rdy_o;
  logic [7:0]              sys_config_i;
  logic [3:0]              user_dip_i;
  logic [3:0]              config_dip_i;
  logic [1:0]              user_led_n_o;
  logic                    geth_reset_n_o;
  logic                    por_force_o;
  logic                    eeprom_wp_o;
  logic                    flash_wp_n_o;
  logic [`BOOT_ADDR_W-1:0] boot_rom_addr_o;
  logic [`BC_DATA_W-1:0]   boot_rom_data_i;
  logic                    boot_done_o;
  logic                    cfg_done_i;
  logic                    cfg_cclk_o;
  logic                    cfg_din_o;
  logic                    cfg_prog_n_o;

  logic [31:0]             lfsr;
  logic [`BOOT_LEN*8-1:0]  rom_image;
  logic [`BOOT_ADDR_W-1:0] rom_addr_q = '0;
  logic [7:0]              rdata;
  int                      cycles;
  int                      err_count;
  int                      check_count;
  int                      pending;
  int                      sva_fails;
  int                      a;

  board_ctrl UUT (.*);

  board_ctrl_checker u_checker (
    .clk_master (clk_master), .reset_mon (reset_mon),
    .host_cs_n_i (host_cs_n_i), .host_we_n_i (host_we_n_i),
    .host_addr_i (host_addr_i), .host_wdata_i (host_wdata_i),
    .host_rdata_i (host_rdata_o), .host_rdy_i (host_rdy_o),
    .sys_config_i (sys_config_i), .user_dip_i (user_dip_i), .config_dip_i (config_dip_i),
    .user_led_n_i (user_led_n_o), .geth_reset_n_i (geth_reset_n_o),
    .por_force_i (por_force_o), .eeprom_wp_i (eeprom_wp_o), .flash_wp_n_i (flash_wp_n_o),
    .boot_done_i (boot_done_o), .cfg_done_i (cfg_done_i), .cfg_cclk_i (cfg_cclk_o),
    .cfg_din_i (cfg_din_o), .cfg_prog_n_i (cfg_prog_n_o), .rom_image_i (rom_image),
    .err_count_o (err_count), .check_count_o (check_count), .pending_o (pending)
  );

  initial begin
    clk_master = 1'b0;
    forever #10 clk_master = ~clk_master;
  end

  // boot rom answers one cycle after the address
  always @(posedge clk_master) rom_addr_q <= boot_rom_addr_o;
  assign #1 boot_rom_data_i = rom_image[rom_addr_q*8 +: 8];

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v[k] = lfsr[0];
    end
    return v;
  endfunction

  // one request, then wait for the ready pulse
  task automatic host_access(input logic we, input logic [4:0] addr, input logic [7:0] wdata);
    @(posedge clk_master);
    #1;
    host_cs_n_i  = 1'b0;
    host_we_n_i  = !we;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    @(posedge clk_master);
    #1;
    host_cs_n_i = 1'b1;
    @(posedge clk_master);
    while (!host_rdy_o) @(posedge clk_master);
    rdata = host_rdata_o;
  endtask

  task automatic drive_switches();
    @(posedge clk_master);
    #1;
    user_dip_i   = 4'(rand_bits(4));
    config_dip_i = 4'(rand_bits(4));
    sys_config_i = 8'(rand_bits(8));
  endtask

  initial begin
    lfsr = 32'h97b8;
    for (a = 0; a < `BOOT_LEN; a++) rom_image[a*8 +: 8] = 8'((a * 8'h4d) ^ 8'ha6);
    host_cs_n_i  = 1'b1;
    host_we_n_i  = 1'b1;
    host_addr_i  = '0;
    host_wdata_i = '0;
    user_dip_i   = 4'(rand_bits(4));
    config_dip_i = 4'(rand_bits(4));
    sys_config_i = 8'(rand_bits(8)) | 8'h02;  // boot copy enabled
    cfg_done_i   = 1'b0;
    reset_mon    = 1'b1;
    repeat (4) @(posedge clk_master);
    #1 reset_mon = 1'b0;

    while (!boot_done_o) host_access(1'b0, 5'(rand_bits(5)), 8'h00);

    for (a = 0; a < 32; a++) host_access(1'b0, 5'(a), 8'h00);

    host_access(1'b1, OFF_CTRL, 8'h08);
    host_access(1'b1, OFF_CTRL, 8'h03);
    repeat (16) begin
      host_access(1'b1, OFF_CTRL, 8'(rand_bits(8)));
      host_access(1'b0, OFF_CTRL, 8'h00);
    end

    repeat (8) begin
      drive_switches();
      host_access(1'b0, OFF_SWITCHES, 8'h00);
      host_access(1'b0, OFF_SYS_CONFIG, 8'h00);
    end

    repeat (4) begin
      @(posedge clk_master);
      #1 cfg_done_i = 1'(rand_bits(1));
      host_access(1'b0, OFF_CFG_STATUS, 8'h00);
    end
    repeat (CFG_BYTES) host_access(1'b1, OFF_CFG_DATA, 8'(rand_bits(8)));
    rdata = 8'hff;
    while (rdata[4:1] != 4'h0) host_access(1'b0, OFF_CFG_STATUS, 8'h00);  // fifo and shifter idle
    host_access(1'b1, OFF_CFG_CTRL, 8'h01);

    while (pending != 0) @(posedge clk_master);
    repeat (4) @(posedge clk_master);
    sva_fails = UUT.u_config_port.u_cfg_sva.fail_count +
                UUT.u_bus_arbiter.u_arb_sva.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, err_count, sva_fails);
    if (err_count == 0 && sva_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_master);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== board_ctrl.f ====
+incdir+source
source/board_ctrl_pkg.sv
source/reg_bus_if.sv
source/host_bus_bridge.sv
source/bus_arbiter.sv
source/misc_regs.sv
source/config_port.sv
source/boot_loader.sv
source/board_ctrl.sv
bench/board_ctrl_sva.sv
bench/board_ctrl_checker.sv
bench/board_ctrl_tb.sv

// ==== source/board_ctrl.sv ====
`include "board_ctrl_defines.svh"

module board_ctrl (
  input  logic                    clk_master,
  input  logic                    reset_mon,
  // host port
  input  logic                    host_cs_n_i,
  input  logic                    host_we_n_i,
  input  logic [`BC_ADDR_W-1:0]   host_addr_i,
  input  logic [`BC_DATA_W-1:0]   host_wdata_i,
  output logic [`BC_DATA_W-1:0]   host_rdata_o,
  output logic                    host_rdy_o,
  // switches and straps
  input  logic [7:0]              sys_config_i,
  input  logic [3:0]              user_dip_i,
  input  logic [3:0]              config_dip_i,
  output logic [1:0]              user_led_n_o,
  output logic                    geth_reset_n_o,
  output logic                    por_force_o,
  output logic                    eeprom_wp_o,
  output logic                    flash_wp_n_o,
  // boot rom
  output logic [`BOOT_ADDR_W-1:0] boot_rom_addr_o,
  input  logic [`BC_DATA_W-1:0]   boot_rom_data_i,
  output logic                    boot_done_o,
  // fpga serial configuration
  input  logic                    cfg_done_i,
  output logic                    cfg_cclk_o,
  output logic                    cfg_din_o,
  output logic                    cfg_prog_n_o
);

  reg_bus_if host_bus ();
  reg_bus_if boot_bus ();
  reg_bus_if misc_bus ();
  reg_bus_if cfg_bus ();

  logic cfg_credit;  // one per byte popped by config_port

  host_bus_bridge u_host_bus_bridge (
    .clk_master   (clk_master),
    .reset_mon    (reset_mon),
    .host_cs_n_i  (host_cs_n_i),
    .host_we_n_i  (host_we_n_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o),
    .host_rdy_o   (host_rdy_o),
    .bus          (host_bus)
  );

  boot_loader u_boot_loader (
    .clk_master      (clk_master),
    .reset_mon       (reset_mon),
    .boot_en_i       (sys_config_i[1]),
    .cfg_credit_i    (cfg_credit),
    .boot_rom_addr_o (boot_rom_addr_o),
    .boot_rom_data_i (boot_rom_data_i),
    .boot_done_o     (boot_done_o),
    .bus             (boot_bus)
  );

  bus_arbiter u_bus_arbiter (
    .clk_master (clk_master),
    .reset_mon  (reset_mon),
    .host_bus   (host_bus),
    .boot_bus   (boot_bus),
    .misc_bus   (misc_bus),
    .cfg_bus    (cfg_bus)
  );

  misc_regs u_misc_regs (
    .clk_master     (clk_master),
    .reset_mon      (reset_mon),
    .bus            (misc_bus),
    .sys_config_i   (sys_config_i),
    .user_dip_i     (user_dip_i),
    .config_dip_i   (config_dip_i),
    .user_led_n_o   (user_led_n_o),
    .geth_reset_n_o (geth_reset_n_o),
    .por_force_o    (por_force_o),
    .eeprom_wp_o    (eeprom_wp_o),
    .flash_wp_n_o   (flash_wp_n_o)
  );

  config_port u_config_port (
    .clk_master   (clk_master),
    .reset_mon    (reset_mon),
    .bus          (cfg_bus),
    .cfg_done_i   (cfg_done_i),
    .cfg_cclk_o   (cfg_cclk_o),
    .cfg_din_o    (cfg_din_o),
    .cfg_prog_n_o (cfg_prog_n_o),
    .cfg_credit_o (cfg_credit)
  );

endmodule

// ==== source/board_ctrl_defines.svh ====
`ifndef BOARD_CTRL_DEFINES_SVH
`define BOARD_CTRL_DEFINES_SVH

// register bus
`define BC_ADDR_W 5
`define BC_DATA_W 8

// configuration path
`define CFG_FIFO_DEPTH 4   // also the initial boot credit count
`define BOOT_LEN 12        // bytes copied from the boot rom
`define BOOT_ADDR_W $clog2(`BOOT_LEN)

// revision readback, high byte first on the bus
`define REV_ID    16'hbc01
`define REV_MAJOR 8'h01
`define REV_MINOR 8'h03
`define REV_RCS   16'h2a5e

`endif

// ==== source/board_ctrl_pkg.sv ====
`include "board_ctrl_defines.svh"

package board_ctrl_pkg;

  // bridge and loader sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_ACK
  } bus_state_t;

  // serializer phases, one bit takes low then high
  typedef enum logic [1:0] {
    SH_IDLE,
    SH_LOW,
    SH_HIGH
  } shift_state_t;

  typedef enum logic {
    M_HOST,
    M_BOOT
  } master_t;

  typedef enum logic [`BC_ADDR_W-1:0] {
    OFF_CTRL       = 5'h00,
    OFF_SWITCHES   = 5'h01,
    OFF_SYS_CONFIG = 5'h02,
    OFF_REV_ID_HI  = 5'h08,
    OFF_REV_ID_LO  = 5'h09,
    OFF_REV_MAJOR  = 5'h0a,
    OFF_REV_MINOR  = 5'h0b,
    OFF_REV_RCS_HI = 5'h0c,
    OFF_REV_RCS_LO = 5'h0d,
    OFF_CFG_DATA   = 5'h10,
    OFF_CFG_STATUS = 5'h11,
    OFF_CFG_CTRL   = 5'h12
  } reg_off_t;

endpackage

// ==== source/boot_loader.sv ====
`include "board_ctrl_defines.svh"

module boot_loader import board_ctrl_pkg::*; (
  input  logic                   clk_master,
  input  logic                   reset_mon,
  input  logic                   boot_en_i,
  input  logic                   cfg_credit_i,
  output logic [`BOOT_ADDR_W-1:0] boot_rom_addr_o,
  input  logic [`BC_DATA_W-1:0]  boot_rom_data_i,
  output logic                   boot_done_o,
  reg_bus_if.master              bus
);

  localparam int CRED_W = $clog2(`CFG_FIFO_DEPTH) + 1;

  bus_state_t             state_q;
  logic                   sampled_q;   // boot_en_i taken once after reset
  logic                   done_q;
  logic [CRED_W-1:0]      credits_q;   // free fifo slots in config_port
  logic [`BOOT_ADDR_W-1:0] rom_addr_q;
  logic                   spend;

  assign spend = (state_q == ST_REQUEST);

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      state_q    <= ST_IDLE;
      sampled_q  <= 1'b0;
      done_q     <= 1'b0;
      credits_q  <= CRED_W'(`CFG_FIFO_DEPTH);
      rom_addr_q <= '0;
      bus.cyc    <= 1'b0;
    end else begin
      credits_q <= credits_q + CRED_W'(cfg_credit_i) - CRED_W'(spend);
      if (!sampled_q) begin
        sampled_q <= 1'b1;
        done_q    <= !boot_en_i;  // nothing to copy
      end
      case (state_q)
        ST_IDLE: begin
          // rom data for rom_addr_q is valid by the request cycle
          if (sampled_q && !done_q && (credits_q != '0)) state_q <= ST_REQUEST;
        end
        ST_REQUEST: begin
          bus.cyc <= 1'b1;
          state_q <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (bus.ack) begin
            bus.cyc <= 1'b0;
            state_q <= ST_IDLE;
            if (rom_addr_q == `BOOT_ADDR_W'(`BOOT_LEN - 1)) begin
              done_q <= 1'b1;
            end else begin
              rom_addr_q <= rom_addr_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_master) begin
    if (spend) bus.wdat <= boot_rom_data_i;
  end

  assign bus.we          = 1'b1;          // writes only
  assign bus.adr         = OFF_CFG_DATA;
  assign boot_rom_addr_o = rom_addr_q;
  assign boot_done_o     = done_q;

endmodule

// ==== source/bus_arbiter.sv ====
`include "board_ctrl_defines.svh"

module bus_arbiter import board_ctrl_pkg::*; (
  input  logic     clk_master,
  input  logic     reset_mon,
  reg_bus_if.slave  host_bus,
  reg_bus_if.slave  boot_bus,
  reg_bus_if.master misc_bus,
  reg_bus_if.master cfg_bus
);

  logic                  busy_q;   // a grant is active
  master_t               grant_q;  // current or last granted master
  master_t               pick;
  logic                  host_req;
  logic                  boot_req;
  logic                  m_cyc;
  logic                  m_we;
  logic [`BC_ADDR_W-1:0] m_adr;
  logic [`BC_DATA_W-1:0] m_wdat;
  logic                  slave_sel; // high selects config_port
  logic                  slave_ack;
  logic [`BC_DATA_W-1:0] slave_rdat;

  assign host_req = host_bus.cyc;
  assign boot_req = boot_bus.cyc;

  // on a tie the master that did not go last wins
  always_comb begin
    if (host_req && boot_req) begin
      pick = (grant_q == M_HOST) ? M_BOOT : M_HOST;
    end else if (boot_req) begin
      pick = M_BOOT;
    end else begin
      pick = M_HOST;
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      busy_q  <= 1'b0;
      grant_q <= M_BOOT;  // host takes the first tie
    end else if (!busy_q) begin
      if (host_req || boot_req) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
      end
    end else if (slave_ack) begin
      busy_q <= 1'b0;
    end
  end

  always_comb begin
    if (grant_q == M_HOST) begin
      m_cyc  = host_bus.cyc;
      m_we   = host_bus.we;
      m_adr  = host_bus.adr;
      m_wdat = host_bus.wdat;
    end else begin
      m_cyc  = boot_bus.cyc;
      m_we   = boot_bus.we;
      m_adr  = boot_bus.adr;
      m_wdat = boot_bus.wdat;
    end
    slave_sel = m_adr[`BC_ADDR_W-1];

    misc_bus.cyc  = busy_q && m_cyc && !slave_sel;
    misc_bus.we   = m_we;
    misc_bus.adr  = m_adr;
    misc_bus.wdat = m_wdat;
    cfg_bus.cyc   = busy_q && m_cyc && slave_sel;
    cfg_bus.we    = m_we;
    cfg_bus.adr   = m_adr;
    cfg_bus.wdat  = m_wdat;

    slave_ack  = slave_sel ? cfg_bus.ack : misc_bus.ack;
    slave_rdat = slave_sel ? cfg_bus.rdat : misc_bus.rdat;

    // only the granted master sees the response
    host_bus.ack  = busy_q && (grant_q == M_HOST) && slave_ack;
    boot_bus.ack  = busy_q && (grant_q == M_BOOT) && slave_ack;
    host_bus.rdat = (grant_q == M_HOST) ? slave_rdat : '0;
    boot_bus.rdat = (grant_q == M_BOOT) ? slave_rdat : '0;
  end

endmodule

// ==== source/config_port.sv ====
`include "board_ctrl_defines.svh"

module config_port import board_ctrl_pkg::*; (
  input  logic     clk_master,
  input  logic     reset_mon,
  reg_bus_if.slave bus,
  input  logic     cfg_done_i,
  output logic     cfg_cclk_o,
  output logic     cfg_din_o,
  output logic     cfg_prog_n_o,
  output logic     cfg_credit_o
);

  localparam int PTR_W    = $clog2(`CFG_FIFO_DEPTH);
  localparam int BIT_W    = $clog2(`BC_DATA_W);
  localparam int PROG_LEN = 8;  // prog_n low time in cycles

  logic [`BC_DATA_W-1:0] fifo_mem [`CFG_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W:0]        fifo_cnt_q;
  logic                  fifo_full;
  logic                  fifo_empty;
  shift_state_t          sh_state_q;
  logic [`BC_DATA_W-1:0] shreg_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic [3:0]            prog_cnt_q;
  logic                  ack_q;
  logic                  credit_q;
  logic                  bus_req;
  logic                  data_wr;
  logic                  push;
  logic                  pop;
  logic                  flush;
  logic                  last_bit;

  assign fifo_full  = (fifo_cnt_q == (PTR_W+1)'(`CFG_FIFO_DEPTH));
  assign fifo_empty = (fifo_cnt_q == '0);
  assign bus_req    = bus.cyc && !ack_q;
  assign data_wr    = bus_req && bus.we && (bus.adr == OFF_CFG_DATA);
  assign push       = data_wr && !fifo_full;  // full fifo stalls the ack
  assign flush      = bus_req && bus.we && (bus.adr == OFF_CFG_CTRL) && bus.wdat[0];
  assign last_bit   = (bit_cnt_q == BIT_W'(`BC_DATA_W - 1));
  // next byte is taken at the end of the last high phase, so no gap
  assign pop = !fifo_empty &&
               ((sh_state_q == SH_IDLE) || ((sh_state_q == SH_HIGH) && last_bit));

  always_ff @(posedge clk_master) begin
    if (push) fifo_mem[wr_ptr_q] <= bus.wdat;
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon || flush) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;  // flushed bytes return no credit
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      fifo_cnt_q <= fifo_cnt_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      sh_state_q <= SH_IDLE;
      bit_cnt_q  <= '0;
      ack_q      <= 1'b0;
      credit_q   <= 1'b0;
      prog_cnt_q <= '0;
    end else begin
      ack_q    <= bus_req && !(data_wr && fifo_full);
      credit_q <= pop;
      case (sh_state_q)
        SH_IDLE: begin
          if (pop) begin
            sh_state_q <= SH_LOW;
            bit_cnt_q  <= '0;
          end
        end
        SH_LOW: sh_state_q <= SH_HIGH;
        SH_HIGH: begin
          if (!last_bit) begin
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            sh_state_q <= SH_LOW;
          end else if (pop) begin
            bit_cnt_q  <= '0;
            sh_state_q <= SH_LOW;
          end else begin
            sh_state_q <= SH_IDLE;
          end
        end
        default: sh_state_q <= SH_IDLE;
      endcase
      if (flush) begin
        prog_cnt_q <= 4'(PROG_LEN);
      end else if (prog_cnt_q != '0) begin
        prog_cnt_q <= prog_cnt_q - 1'b1;
      end
    end
  end

  // msb goes out first, shifted after each high phase
  always_ff @(posedge clk_master) begin
    if (pop) begin
      shreg_q <= fifo_mem[rd_ptr_q];
    end else if (sh_state_q == SH_HIGH) begin
      shreg_q <= shreg_q << 1;
    end
  end

  always_comb begin
    case (bus.adr)
      OFF_CFG_STATUS: bus.rdat = {{(`BC_DATA_W-PTR_W-3){1'b0}}, fifo_cnt_q,
                                  (sh_state_q != SH_IDLE), cfg_done_i};
      OFF_CFG_CTRL:   bus.rdat = {{(`BC_DATA_W-1){1'b0}}, (prog_cnt_q != '0)};
      default:        bus.rdat = '0;
    endcase
  end

  assign bus.ack      = ack_q;
  assign cfg_cclk_o   = (sh_state_q == SH_HIGH);
  assign cfg_din_o    = shreg_q[`BC_DATA_W-1];
  assign cfg_prog_n_o = (prog_cnt_q == '0);
  assign cfg_credit_o = credit_q;

endmodule

// ==== source/host_bus_bridge.sv ====
`include "board_ctrl_defines.svh"

module host_bus_bridge import board_ctrl_pkg::*; (
  input  logic                  clk_master,
  input  logic                  reset_mon,
  input  logic                  host_cs_n_i,
  input  logic                  host_we_n_i,
  input  logic [`BC_ADDR_W-1:0] host_addr_i,
  input  logic [`BC_DATA_W-1:0] host_wdata_i,
  output logic [`BC_DATA_W-1:0] host_rdata_o,
  output logic                  host_rdy_o,
  reg_bus_if.master             bus
);

  bus_state_t            state_q;
  logic [`BC_DATA_W-1:0] rdata_q;
  logic                  rdy_q;
  logic                  take_req;
  logic                  done;

  assign take_req = (state_q == ST_IDLE) && !host_cs_n_i;
  assign done     = (state_q == ST_WAIT_ACK) && bus.ack;

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      state_q <= ST_IDLE;
      bus.cyc <= 1'b0;
      rdy_q   <= 1'b0;
    end else begin
      rdy_q <= 1'b0;  // one-cycle pulse
      case (state_q)
        ST_IDLE: begin
          if (!host_cs_n_i) state_q <= ST_REQUEST;
        end
        ST_REQUEST: begin
          bus.cyc <= 1'b1;
          state_q <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (bus.ack) begin
            bus.cyc <= 1'b0;  // drop in the cycle after ack
            rdy_q   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload and returned data
  always_ff @(posedge clk_master) begin
    if (take_req) begin
      bus.we   <= !host_we_n_i;
      bus.adr  <= host_addr_i;
      bus.wdat <= host_wdata_i;
    end
    if (done) rdata_q <= bus.rdat;
  end

  assign host_rdata_o = rdata_q;
  assign host_rdy_o   = rdy_q;

endmodule

// ==== source/misc_regs.sv ====
`include "board_ctrl_defines.svh"

module misc_regs import board_ctrl_pkg::*; (
  input  logic       clk_master,
  input  logic       reset_mon,
  reg_bus_if.slave   bus,
  input  logic [7:0] sys_config_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  output logic [1:0] user_led_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_o,
  output logic       eeprom_wp_o,
  output logic       flash_wp_n_o
);

  logic [3:0] ctrl_q;       // leds, eth reset, por force request
  logic       por_force_q;
  logic       ack_q;
  logic       ctrl_wr;

  assign ctrl_wr = bus.cyc && bus.we && !ack_q && (bus.adr == OFF_CTRL);

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      ctrl_q      <= '0;
      por_force_q <= 1'b0;
      ack_q       <= 1'b0;
    end else begin
      ack_q <= bus.cyc && !ack_q;  // one cycle after cyc
      if (ctrl_wr) begin
        ctrl_q <= bus.wdat[3:0];
        // rising write of bit 3 latches until reset
        if (bus.wdat[3] && !ctrl_q[3]) por_force_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (bus.adr)
      OFF_CTRL:       bus.rdat = {{(`BC_DATA_W-4){1'b0}}, ctrl_q};
      OFF_SWITCHES:   bus.rdat = {config_dip_i, user_dip_i};
      OFF_SYS_CONFIG: bus.rdat = sys_config_i;
      OFF_REV_ID_HI:  bus.rdat = 8'((`REV_ID) >> 8);
      OFF_REV_ID_LO:  bus.rdat = 8'(`REV_ID);
      OFF_REV_MAJOR:  bus.rdat = `REV_MAJOR;
      OFF_REV_MINOR:  bus.rdat = `REV_MINOR;
      OFF_REV_RCS_HI: bus.rdat = 8'((`REV_RCS) >> 8);
      OFF_REV_RCS_LO: bus.rdat = 8'(`REV_RCS);
      default:        bus.rdat = '0;
    endcase
  end

  assign bus.ack = ack_q;

  assign user_led_n_o   = ~ctrl_q[1:0];  // leds are active low
  assign geth_reset_n_o = !ctrl_q[2];
  assign por_force_o    = por_force_q;
  assign eeprom_wp_o    = !user_dip_i[3];
  assign flash_wp_n_o   = !user_dip_i[2];

endmodule

// ==== source/reg_bus_if.sv ====
`include "board_ctrl_defines.svh"

interface reg_bus_if;
  logic                  cyc;  // held by the master until ack
  logic                  we;
  logic [`BC_ADDR_W-1:0] adr;
  logic [`BC_DATA_W-1:0] wdat;
  logic [`BC_DATA_W-1:0] rdat; // valid with ack on reads
  logic                  ack;  // single cycle

  modport master (
    output cyc, we, adr, wdat,
    input  rdat, ack
  );

  modport slave (
    input  cyc, we, adr, wdat,
    output rdat, ack
  );

endinterface
